// ==== Makefile ====
TOP = wave_classifier_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f project.f -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir sim.log

// ==== logic/peak_trigger.sv ====
`timescale 1ns/1ns

module peak_trigger (
    input  logic              clk,
    input  logic              rst_n,
    input  wave_pkg::sample_t in_data,
    input  logic              in_valid,
    output logic              in_ready,
    input  wave_pkg::cfg_t    cfg,
    input  logic              result_taken,
    output logic              sample_fire,
    output logic              win_start,
    output logic              win_last,
    output logic [7:0]        sample_d
);

    import wave_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_collect,
        st_wait
    } state_e;

    state_e     state;
    logic [7:0] sample_cnt;
    logic [8:0] peak_dist;
    logic       near_peak;
    logic       accept;

    // distance from the configured peak
    assign peak_dist = (in_data.value >= cfg.amplitude) ?
                       ({1'b0, in_data.value} - {1'b0, cfg.amplitude}) :
                       ({1'b0, cfg.amplitude} - {1'b0, in_data.value});
    assign near_peak = (peak_dist <= 9'(peak_threshold));

    // no intake while a result waits
    assign in_ready    = (state != st_wait);
    assign accept      = in_valid && in_ready;
    assign win_start   = accept && (state == st_idle) && near_peak;
    assign win_last    = accept && (state == st_collect) &&
                         (sample_cnt == 8'(window_len - 1));
    assign sample_fire = win_start || (accept && (state == st_collect));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_idle;
            sample_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    // trigger sample is window sample 0
                    if (win_start) begin
                        state      <= st_collect;
                        sample_cnt <= 8'd1;
                    end
                end
                st_collect: begin
                    if (sample_fire) begin
                        sample_cnt <= sample_cnt + 8'd1;
                    end
                    if (win_last) begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (result_taken) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // aligned with the template outputs
    always_ff @(posedge clk) begin
        if (sample_fire) begin
            sample_d <= in_data.value;
        end
    end

endmodule

// ==== logic/sad_classifier.sv ====
`timescale 1ns/1ns

module sad_classifier (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              acc_en,
    input  logic              acc_clear,
    input  logic              acc_last,
    input  logic [7:0]        sample,
    input  logic [7:0]        dwave,
    input  wave_pkg::tmpl_t   tmpl,
    output wave_pkg::result_t result,
    output logic              out_valid,
    input  logic              out_ready,
    output logic              result_taken
);

    import wave_pkg::*;

    logic [score_w-1:0] tri_acc;
    logic [score_w-1:0] sqr_acc;
    logic [score_w-1:0] sin_acc;
    logic [score_w-1:0] tri_step;
    logic [score_w-1:0] sqr_step;
    logic [score_w-1:0] sin_step;
    logic               scores_done;
    wave_type_e         winner;

    function automatic logic [7:0] abs_diff(input logic [7:0] a, input logic [7:0] b);
        return (a >= b) ? (a - b) : (b - a);
    endfunction

    // triangle uses both the wave and its slope
    assign tri_step = score_w'(abs_diff(sample, tmpl.tri_wave)) +
                      score_w'(abs_diff(dwave, tmpl.dsqr));
    // single-term scores doubled to the same scale
    assign sqr_step = score_w'({abs_diff(sample, tmpl.sqr), 1'b0});
    assign sin_step = score_w'({abs_diff(dwave, tmpl.tri_q), 1'b0});

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tri_acc <= '0;
            sqr_acc <= '0;
            sin_acc <= '0;
        end else if (acc_en) begin
            if (acc_clear) begin
                tri_acc <= tri_step;
                sqr_acc <= sqr_step;
                sin_acc <= sin_step;
            end else begin
                tri_acc <= tri_acc + tri_step;
                sqr_acc <= sqr_acc + sqr_step;
                sin_acc <= sin_acc + sin_step;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scores_done <= 1'b0;
        end else begin
            scores_done <= acc_last;
        end
    end

    // ties go to triangle, then square
    always_comb begin
        if ((tri_acc <= sqr_acc) && (tri_acc <= sin_acc)) begin
            winner = triangle;
        end else if (sqr_acc <= sin_acc) begin
            winner = square;
        end else begin
            winner = sine;
        end
    end

    assign result_taken = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (scores_done) begin
            out_valid <= 1'b1;
        end else if (result_taken) begin
            out_valid <= 1'b0;
        end
    end

    // held stable until the handshake, no new window can start before it
    always_ff @(posedge clk) begin
        if (scores_done) begin
            result.wave_type <= winner;
            result.tri_score <= tri_acc;
            result.sqr_score <= sqr_acc;
            result.sin_score <= sin_acc;
        end
    end

endmodule

// ==== logic/sqr_template_gen.sv ====
`timescale 1ns/1ns

module sqr_template_gen (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           sample_fire,
    input  logic           win_start,
    input  wave_pkg::cfg_t cfg,
    output logic [7:0]     sqr,
    output logic [7:0]     dsqr
);

    import wave_pkg::*;

    cfg_t            cfg_q;
    cfg_t            cfg_use;
    logic [ph_w-1:0] phase;
    logic [ph_w-1:0] phase_use;
    logic [7:0]      low_level;

    assign phase_use = win_start ? '0 : phase;
    assign cfg_use   = win_start ? cfg : cfg_q;
    // 256 minus amplitude, mod 256
    assign low_level = 8'd0 - cfg_use.amplitude;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (sample_fire) begin
            phase <= phase_use + cfg_use.freq_word;
        end
    end

    always_ff @(posedge clk) begin
        if (sample_fire) begin
            sqr  <= phase_use[ph_w-1] ? low_level : cfg_use.amplitude;
            // falling half first, like the triangle
            dsqr <= phase_use[ph_w-1] ? 8'(128 + slope_mag) : 8'(128 - slope_mag);
        end
    end

    always_ff @(posedge clk) begin
        if (sample_fire && win_start) begin
            cfg_q <= cfg;
        end
    end

endmodule

// ==== logic/tri_template_gen.sv ====
`timescale 1ns/1ns

module tri_template_gen (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           sample_fire,
    input  logic           win_start,
    input  wave_pkg::cfg_t cfg,
    output logic [7:0]     tri_wave,
    output logic [7:0]     tri_q
);

    import wave_pkg::*;

    cfg_t            cfg_q;
    cfg_t            cfg_use;
    logic [ph_w-1:0] phase;
    logic [ph_w-1:0] phase_use;
    logic [ph_w-1:0] phase_q;

    // fold phase into a ramp from amp down to 256-amp and back
    function automatic logic [7:0] ramp(input logic [ph_w-1:0] p, input logic [7:0] amp);
        logic [7:0]  pos;
        logic [7:0]  span;
        logic [15:0] drop;
        pos  = p[ph_w-1] ? ~p[ph_w-2 -: 8] : p[ph_w-2 -: 8];
        // 2*amp - 256, amp above the midline
        span = {amp[6:0], 1'b0};
        drop = span * pos;
        return amp - drop[15:8];
    endfunction

    // window sample 0 starts at phase zero, the peak
    assign phase_use = win_start ? '0 : phase;
    assign cfg_use   = win_start ? cfg : cfg_q;
    assign phase_q   = phase_use + {2'b11, {(ph_w-2){1'b0}}};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (sample_fire) begin
            phase <= phase_use + cfg_use.freq_word;
        end
    end

    always_ff @(posedge clk) begin
        if (sample_fire) begin
            tri_wave <= ramp(phase_use, cfg_use.amplitude);
            tri_q    <= ramp(phase_q, cfg_use.amplitude);
        end
    end

    always_ff @(posedge clk) begin
        if (sample_fire && win_start) begin
            cfg_q <= cfg;
        end
    end

endmodule

// ==== logic/wave_classifier_top.sv ====
`timescale 1ns/1ns

module wave_classifier_top (
    input  logic              clk,
    input  logic              rst_n,
    input  wave_pkg::cfg_t    cfg,
    input  wave_pkg::sample_t in_data,
    input  logic              in_valid,
    output logic              in_ready,
    output wave_pkg::result_t result,
    output logic              out_valid,
    input  logic              out_ready
);

    import wave_pkg::*;

    logic       sample_fire;
    logic       win_start;
    logic       win_last;
    logic       result_taken;
    logic       acc_en;
    logic       acc_clear;
    logic       acc_last;
    logic [7:0] sample_d;
    logic [7:0] dwave;
    logic [7:0] tri_wave;
    logic [7:0] tri_q;
    logic [7:0] sqr;
    logic [7:0] dsqr;
    tmpl_t      tmpl;

    peak_trigger peak_trigger_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_data      (in_data),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .cfg          (cfg),
        .result_taken (result_taken),
        .sample_fire  (sample_fire),
        .win_start    (win_start),
        .win_last     (win_last),
        .sample_d     (sample_d)
    );

    wave_derivative wave_derivative_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_fire (sample_fire),
        .win_start   (win_start),
        .sample      (in_data.value),
        .dwave       (dwave)
    );

    tri_template_gen tri_template_gen_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_fire (sample_fire),
        .win_start   (win_start),
        .cfg         (cfg),
        .tri_wave    (tri_wave),
        .tri_q       (tri_q)
    );

    sqr_template_gen sqr_template_gen_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_fire (sample_fire),
        .win_start   (win_start),
        .cfg         (cfg),
        .sqr         (sqr),
        .dsqr        (dsqr)
    );

    // strobes follow the registered sample, derivative and templates
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_en    <= 1'b0;
            acc_clear <= 1'b0;
            acc_last  <= 1'b0;
        end else begin
            acc_en    <= sample_fire;
            acc_clear <= win_start;
            acc_last  <= win_last;
        end
    end

    assign tmpl.tri_wave = tri_wave;
    assign tmpl.tri_q    = tri_q;
    assign tmpl.sqr      = sqr;
    assign tmpl.dsqr     = dsqr;

    sad_classifier sad_classifier_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .acc_en       (acc_en),
        .acc_clear    (acc_clear),
        .acc_last     (acc_last),
        .sample       (sample_d),
        .dwave        (dwave),
        .tmpl         (tmpl),
        .result       (result),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .result_taken (result_taken)
    );

endmodule

// ==== logic/wave_derivative.sv ====
`timescale 1ns/1ns

module wave_derivative (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sample_fire,
    input  logic       win_start,
    input  logic [7:0] sample,
    output logic [7:0] dwave
);

    logic [7:0]        prev_sample;
    logic signed [9:0] diff;

    // midline-offset difference, range -127..383 before saturation
    assign diff = $signed({2'b00, sample}) - $signed({2'b00, prev_sample}) + 10'sd128;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dwave <= 8'd128;
        end else if (sample_fire) begin
            if (win_start) begin
                // no previous sample inside the window yet
                dwave <= 8'd128;
            end else if (diff < 10'sd0) begin
                dwave <= 8'd0;
            end else if (diff > 10'sd255) begin
                dwave <= 8'd255;
            end else begin
                dwave <= diff[7:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_fire) begin
            prev_sample <= sample;
        end
    end

endmodule

// ==== logic/wave_pkg.sv ====
package wave_pkg;

    localparam int data_w         = 8;
    localparam int ph_w           = 32;
    localparam int peak_threshold = 4;
    localparam int window_len     = 256;
    localparam int score_w        = 18;
    localparam int slope_mag      = 16;

    // host configuration, sampled when a window opens
    typedef struct packed {
        logic [ph_w-1:0]   freq_word;
        logic [data_w-1:0] amplitude;
    } cfg_t;

    // unsigned sample, 128 is the midline
    typedef struct packed {
        logic [data_w-1:0] value;
    } sample_t;

    // template values for one accepted sample
    typedef struct packed {
        logic [data_w-1:0] tri_wave;
        logic [data_w-1:0] tri_q;
        logic [data_w-1:0] sqr;
        logic [data_w-1:0] dsqr;
    } tmpl_t;

    typedef enum logic [1:0] {
        triangle = 2'd0,
        square   = 2'd1,
        sine     = 2'd2
    } wave_type_e;

    typedef struct packed {
        wave_type_e         wave_type;
        logic [score_w-1:0] tri_score;
        logic [score_w-1:0] sqr_score;
        logic [score_w-1:0] sin_score;
    } result_t;

endpackage

// ==== project.f ====
logic/wave_pkg.sv
logic/peak_trigger.sv
logic/wave_derivative.sv
logic/tri_template_gen.sv
logic/sqr_template_gen.sv
logic/sad_classifier.sv
logic/wave_classifier_top.sv
sim/wave_classifier_tb.sv

// ==== sim/wave_classifier_tb.sv ====
`timescale 1ns/1ns

module wave_classifier_tb;

    import wave_pkg::*;

    logic       clk;
    logic       rst_n;
    cfg_t       cfg;
    sample_t    in_data;
    logic       in_valid;
    logic       in_ready;
    result_t    result;
    logic       out_valid;
    logic       out_ready;

    logic [7:0] wave [window_len];
    result_t    exp_res;
    cfg_t       tri_cfg;
    cfg_t       sin_cfg;
    int         cycle;
    int         last_cyc;
    int         checks;
    int         errors;
    integer     seed;
    bit         aborted;

    wave_classifier_top wave_classifier_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .result    (result),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic int abs_int(input int v);
        return (v < 0) ? -v : v;
    endfunction

    // peak at phase zero and low point at half period
    function automatic int tri_level(input logic [31:0] p, input int amp);
        int h;
        h = p[31] ? 255 - int'(p[30:23]) : int'(p[30:23]);
        return amp - ((2 * amp - 256) * h) / 256;
    endfunction

    function automatic int sqr_level(input logic [31:0] p, input int amp);
        return p[31] ? 256 - amp : amp;
    endfunction

    function automatic int slope_level(input logic [31:0] p);
        return p[31] ? 128 + slope_mag : 128 - slope_mag;
    endfunction

    task automatic build_wave(input wave_type_e kind, input cfg_t c);
        logic [31:0] p;
        int          level;
        p = '0;
        level = int'(c.amplitude);
        for (int n = 0; n < window_len; n++) begin
            case (kind)
                triangle: wave[n] = 8'(tri_level(p, int'(c.amplitude)));
                square:   wave[n] = 8'(sqr_level(p, int'(c.amplitude)));
                default: begin
                    // slope tracks the 270-degree triangle
                    // odd samples trimmed by one so the level does not drift
                    if (n > 0) begin
                        level += tri_level(p + 32'hc000_0000, int'(c.amplitude)) - 128 - (n % 2);
                    end
                    wave[n] = 8'(level);
                end
            endcase
            p = p + c.freq_word;
        end
    endtask

    task automatic compute_expected(input cfg_t c);
        logic [31:0] p;
        int          amp;
        int          cur;
        int          d;
        int          tri_sum;
        int          sqr_sum;
        int          sin_sum;
        p = '0;
        amp = int'(c.amplitude);
        tri_sum = 0;
        sqr_sum = 0;
        sin_sum = 0;
        for (int n = 0; n < window_len; n++) begin
            cur = int'(wave[n]);
            d = 128;
            if (n > 0) begin
                d = cur - int'(wave[n-1]) + 128;
                d = (d < 0) ? 0 : ((d > 255) ? 255 : d);
            end
            tri_sum += abs_int(cur - tri_level(p, amp)) + abs_int(d - slope_level(p));
            sqr_sum += 2 * abs_int(cur - sqr_level(p, amp));
            sin_sum += 2 * abs_int(d - tri_level(p + 32'hc000_0000, amp));
            p = p + c.freq_word;
        end
        exp_res.tri_score = score_w'(tri_sum);
        exp_res.sqr_score = score_w'(sqr_sum);
        exp_res.sin_score = score_w'(sin_sum);
        if ((tri_sum <= sqr_sum) && (tri_sum <= sin_sum)) begin
            exp_res.wave_type = triangle;
        end else if (sqr_sum <= sin_sum) begin
            exp_res.wave_type = square;
        end else begin
            exp_res.wave_type = sine;
        end
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic send_window(input cfg_t c, input bit gaps);
        int sent;
        int guard;
        sent = 0;
        guard = 0;
        @(posedge clk);
        cfg           <= c;
        in_data.value <= wave[0];
        in_valid      <= 1'b1;
        while ((sent < window_len) && !aborted) begin
            @(posedge clk);
            if (in_valid && in_ready) begin
                sent++;
                last_cyc = cycle;
            end
            guard++;
            if (guard > 4 * window_len) begin
                errors++;
                aborted = 1'b1;
                $display("timeout at %0t: window samples are not accepted", $time);
                in_valid <= 1'b0;
            end else if ((sent < window_len) && gaps && (($random(seed) & 3) == 0)) begin
                in_valid <= 1'b0;
            end else if (sent < window_len) begin
                in_valid      <= 1'b1;
                in_data.value <= wave[sent];
            end else begin
                in_valid <= 1'b0;
            end
        end
    endtask

    task automatic expect_result(input wave_type_e intended);
        int waited;
        waited = 0;
        @(posedge clk);
        while (!out_valid && !aborted) begin
            waited++;
            if (waited > 10) begin
                errors++;
                aborted = 1'b1;
                $display("timeout at %0t: no result after the window", $time);
            end else begin
                @(posedge clk);
            end
        end
        if (!aborted) begin
            // set on the second edge after the last sample and seen on the next one
            check_val("out_valid latency", 64'(cycle - last_cyc - 1), 64'd2);
            checks++;
            assert (exp_res.wave_type == intended) else begin
                errors++;
                $display("reference model picks %0d instead of %0d", exp_res.wave_type, intended);
            end
            check_val("wave_type", result.wave_type, exp_res.wave_type);
            check_val("tri_score", result.tri_score, exp_res.tri_score);
            check_val("sqr_score", result.sqr_score, exp_res.sqr_score);
            check_val("sin_score", result.sin_score, exp_res.sin_score);
        end
    endtask

    task automatic run_shape(input wave_type_e kind, input cfg_t c, input bit gaps);
        if (!aborted) begin
            build_wave(kind, c);
            compute_expected(c);
            send_window(c, gaps);
            expect_result(kind);
        end
    endtask

    task automatic far_samples_test();
        if (!aborted) begin
            @(posedge clk);
            cfg           <= tri_cfg;
            in_data.value <= 8'd100;
            in_valid      <= 1'b1;
            for (int n = 0; n < 300; n++) begin
                @(posedge clk);
                check_val("in_ready", in_ready, 64'd1);
                check_val("out_valid", out_valid, 64'd0);
            end
            in_valid <= 1'b0;
        end
    endtask

    task automatic backpressure_test();
        result_t held;
        if (!aborted) begin
            build_wave(square, tri_cfg);
            compute_expected(tri_cfg);
            @(posedge clk);
            out_ready <= 1'b0;
            send_window(tri_cfg, 1'b0);
            expect_result(square);
        end
        if (!aborted) begin
            held = result;
            // a waiting peak sample would open a window if taken
            in_data.value <= tri_cfg.amplitude;
            in_valid      <= 1'b1;
            for (int n = 0; n < 20; n++) begin
                @(posedge clk);
                check_val("in_ready", in_ready, 64'd0);
                check_val("out_valid", out_valid, 64'd1);
                check_val("result", result, held);
            end
            out_ready <= 1'b1;
            @(posedge clk);
            in_valid <= 1'b0;
            check_val("in_ready", in_ready, 64'd0);
            run_shape(triangle, tri_cfg, 1'b0);
        end
    endtask

    initial begin
        tri_cfg   = '{freq_word: 32'h0200_0000, amplitude: 8'd200};
        sin_cfg   = '{freq_word: 32'h0800_0000, amplitude: 8'd136};
        clk       = 1'b0;
        rst_n     = 1'b0;
        cfg       = tri_cfg;
        in_data   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        cycle     = 0;
        last_cyc  = 0;
        checks    = 0;
        errors    = 0;
        aborted   = 1'b0;
        seed      = 32'hebc7_eee9;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_val("in_ready", in_ready, 64'd1);
        check_val("out_valid", out_valid, 64'd0);
        run_shape(triangle, tri_cfg, 1'b0);
        run_shape(square, tri_cfg, 1'b0);
        run_shape(sine, sin_cfg, 1'b0);
        far_samples_test();
        backpressure_test();
        run_shape(triangle, tri_cfg, 1'b1);
        run_shape(square, tri_cfg, 1'b1);
        finish_run();
    end

endmodule
